/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_xlate_tb
FILELIST  ?= mem_xlate.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* mem_xlate.f */
+incdir+verilog
verilog/mem_xlate_pkg.sv
verilog/mem_xlate_if.sv
verilog/access_decode.sv
verilog/tlb_check.sv
verilog/access_result.sv
verilog/mem_xlate.sv
sim/mem_xlate_chk.sv
sim/mem_xlate_tb.sv

/* sim/mem_xlate_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_xlate_chk (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] wstrb,
    input logic       exc,
    input logic       dcache_valid,
    input logic       uncache_valid
);

    int fail_count = 0;

    a_strobe_no_exc: assert property (@(posedge clk) disable iff (!rst_n)
        (wstrb != 4'b0000) |-> !exc)
        else begin
            fail_count++;
            $error("write strobes set together with an exception");
        end

    // cached and uncached paths exclusive
    a_one_path: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcache_valid && uncache_valid))
        else begin
            fail_count++;
            $error("dcache_valid and uncache_valid high together");
        end

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!dcache_valid && !uncache_valid))
        else begin
            fail_count++;
            $error("access strobe high during reset");
        end

endmodule

bind mem_xlate mem_xlate_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .wstrb         (wstrb),
    .exc           (exc),
    .dcache_valid  (dcache_valid),
    .uncache_valid (uncache_valid)
);

`default_nettype wire

/* sim/mem_xlate_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xlate_consts.svh"

module mem_xlate_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int TEST_REQS      = 300;
    localparam int MIX_REQS       = 400;
    localparam int TIMEOUT_CYCLES = 3000; // six tests of at most 400 requests plus reset and drain

    typedef struct {
        logic [31:0] paddr;
        logic        uncached;
        logic        dcache_valid;
        logic        uncache_valid;
        logic [3:0]  wstrb;
        logic        exc;
        logic [4:0]  exc_code;
        logic [31:0] badvaddr;
        logic        tlb_refill;
        int          due; // cycle in which the result shows up
    } expect_t;

    logic        clk, rst_n, req_valid, is_load, is_store, overflow, in_exc, eret_flush;
    logic [31:0] vaddr, pc;
    logic [2:0]  dm_sel;
    logic [4:0]  in_exc_code;
    logic        tlb_found, tlb_v, tlb_d;
    logic [19:0] tlb_pfn;
    logic        out_valid, uncached, dcache_valid, uncache_valid, exc, tlb_refill;
    logic [31:0] paddr, badvaddr;
    logic [3:0]  wstrb;
    logic [4:0]  exc_code;

    integer  seed = 32'hba27b4a5;
    int      cycle_count = 0;
    int      error_count = 0;
    int      check_count = 0;
    expect_t exp_q[$];

    mem_xlate dut (
        .clk (clk), .rst_n (rst_n), .req_valid (req_valid), .vaddr (vaddr),
        .is_load (is_load), .is_store (is_store), .dm_sel (dm_sel), .overflow (overflow),
        .in_exc (in_exc), .in_exc_code (in_exc_code), .pc (pc), .eret_flush (eret_flush),
        .tlb_found (tlb_found), .tlb_v (tlb_v), .tlb_d (tlb_d), .tlb_pfn (tlb_pfn),
        .out_valid (out_valid), .paddr (paddr), .uncached (uncached),
        .dcache_valid (dcache_valid), .uncache_valid (uncache_valid), .wstrb (wstrb),
        .exc (exc), .exc_code (exc_code), .badvaddr (badvaddr), .tlb_refill (tlb_refill)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // expected outputs for the inputs currently driven
    function automatic expect_t model_expect();
        expect_t    e;
        logic       st, ld, mapped, misaligned, live, bad_entry;
        logic [1:0] size; // 0 byte, 1 half, 2 word
        st     = is_store;
        ld     = is_load && !is_store;
        mapped = (vaddr[31:30] != 2'b10);
        if (st) begin
            size = (dm_sel == `MX_SEL_BYTE) ? 2'd0 : (dm_sel == `MX_SEL_HALF) ? 2'd1 : 2'd2;
            misaligned = (dm_sel == `MX_SEL_WORD && vaddr[1:0] != 2'b00) ||
                         (dm_sel == `MX_SEL_HALF && vaddr[0]);
        end else begin
            size = (dm_sel == `MX_SEL_LW) ? 2'd2 :
                   (dm_sel == `MX_SEL_LH || dm_sel == `MX_SEL_LHU) ? 2'd1 : 2'd0;
            misaligned = ld && ((size == 2'd2 && vaddr[1:0] != 2'b00) ||
                                (size == 2'd1 && vaddr[0]));
        end
        e.paddr      = mapped ? {tlb_pfn, vaddr[11:0]} : {3'b000, vaddr[28:0]};
        e.uncached   = (e.paddr[31:16] == 16'h1faf);
        e.exc        = 1'b1;
        e.exc_code   = in_exc_code;
        e.badvaddr   = vaddr;
        e.tlb_refill = 1'b0;
        bad_entry    = !tlb_found || !tlb_v;
        if (in_exc) begin
            e.badvaddr = pc; // earlier exception wins
        end else if (overflow) begin
            e.exc_code = `MX_EXC_OV;
            e.badvaddr = 32'h0;
        end else if (st && misaligned) begin
            e.exc_code = `MX_EXC_ADES;
        end else if (ld && misaligned) begin
            e.exc_code = `MX_EXC_ADEL;
        end else if (mapped && st && bad_entry) begin
            e.exc_code   = `MX_EXC_TLBS;
            e.tlb_refill = !tlb_found;
        end else if (mapped && st && !tlb_d) begin
            e.exc_code = `MX_EXC_MOD;
        end else if (mapped && ld && bad_entry) begin
            e.exc_code   = `MX_EXC_TLBL;
            e.tlb_refill = !tlb_found;
        end else begin
            e.exc = 1'b0;
        end
        live            = (st || ld) && !e.exc && !eret_flush;
        e.dcache_valid  = live && !e.uncached;
        e.uncache_valid = live && e.uncached;
        e.wstrb         = 4'b0000;
        if (live && st) begin
            case (size)
                2'd0:    e.wstrb[e.paddr[1:0]] = 1'b1;
                2'd1:    e.wstrb[{e.paddr[1], 1'b0} +: 2] = 2'b11;
                default: e.wstrb = 4'b1111;
            endcase
        end
        e.due = cycle_count + 2;
        return e;
    endfunction

    // mode picks which corner of the request space gets exercised
    task automatic make_request(input int mode);
        logic [31:0] r, s;
        r           = $random(seed);
        s           = $random(seed);
        req_valid   = 1'b1;
        vaddr       = $random(seed);
        pc          = $random(seed);
        is_store    = r[0];
        is_load     = !r[0];
        dm_sel      = r[3:1];
        in_exc_code = r[8:4];
        overflow    = 1'b0;
        in_exc      = 1'b0;
        eret_flush  = 1'b0;
        tlb_found   = 1'b1;
        tlb_v       = 1'b1;
        tlb_d       = 1'b1;
        tlb_pfn     = s[19:0];
        if (mode == 1 || mode == 2 || mode == 4) vaddr[1:0] = 2'b00;
        if (mode == 2 || mode == 4) vaddr[31] = vaddr[31] & ~(vaddr[30] ^ vaddr[31]);
        case (mode)
            1: begin
                vaddr[31:30] = 2'b10;
                if (r[9]) vaddr[28:16] = 13'h1faf; // uncached window
            end
            2: if (r[9]) tlb_pfn[19:4] = 16'h1faf;
            4: begin
                tlb_found = r[10];
                tlb_v     = r[11];
                tlb_d     = r[12];
            end
            5: begin
                overflow   = r[13];
                in_exc     = r[14];
                eret_flush = r[15];
            end
            6: begin
                req_valid  = r[17] | r[18];
                is_load    = r[16];
                overflow   = r[13] & r[19];
                in_exc     = r[14] & r[20];
                eret_flush = r[15] & r[21];
                tlb_found  = r[10] | r[22];
                tlb_v      = r[11] | r[23];
                tlb_d      = r[12];
            end
            default: ;
        endcase
    endtask

    task automatic run_test(input string name, input int mode, input int count);
        int start_errors;
        start_errors = error_count;
        for (int i = 0; i < count; i++) begin
            make_request(mode);
            if (req_valid) exp_q.push_back(model_expect());
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        #1;
        $display("test %-10s done: %0d requests, %0d errors", name, count,
                 error_count - start_errors);
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: output valid with no request in flight", $time);
                error_count++;
            end else begin
                e = exp_q.pop_front();
                if (e.due != cycle_count) begin
                    $display("ERROR at %0t: result due in cycle %0d came in cycle %0d",
                             $time, e.due, cycle_count);
                    error_count++;
                end
                check_value("paddr", e.paddr, paddr);
                check_value("uncached", 32'(e.uncached), 32'(uncached));
                check_value("dcache_valid", 32'(e.dcache_valid), 32'(dcache_valid));
                check_value("uncache_valid", 32'(e.uncache_valid), 32'(uncache_valid));
                check_value("wstrb", 32'(e.wstrb), 32'(wstrb));
                check_value("exc", 32'(e.exc), 32'(exc));
                check_value("tlb_refill", 32'(e.tlb_refill), 32'(tlb_refill));
                if (e.exc) begin
                    check_value("exc_code", 32'(e.exc_code), 32'(exc_code));
                    check_value("badvaddr", e.badvaddr, badvaddr);
                end
            end
        end else if (rst_n) begin
            check_value("idle strobes", 32'h0,
                        32'({dcache_valid, uncache_valid, wstrb, exc, tlb_refill}));
            if (exp_q.size() != 0 && exp_q[0].due <= cycle_count) begin
                $display("ERROR at %0t: result due in cycle %0d never appeared",
                         $time, exp_q[0].due);
                error_count++;
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        int total_errors;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        vaddr       = 32'h0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        dm_sel      = 3'b000;
        overflow    = 1'b0;
        in_exc      = 1'b0;
        in_exc_code = 5'd0;
        pc          = 32'h0;
        eret_flush  = 1'b0;
        tlb_found   = 1'b0;
        tlb_v       = 1'b0;
        tlb_d       = 1'b0;
        tlb_pfn     = 20'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        run_test("unmapped", 1, TEST_REQS);
        run_test("mapped_hit", 2, TEST_REQS);
        run_test("misaligned", 3, TEST_REQS);
        run_test("tlb_fault", 4, TEST_REQS);
        run_test("priority", 5, TEST_REQS);
        run_test("random_mix", 6, MIX_REQS);
        total_errors = error_count + dut.u_chk.fail_count;
        $display("tests 6, checks %0d, assertion failures %0d, errors %0d",
                 check_count, dut.u_chk.fail_count, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xlate_consts.svh"

module access_decode import mem_xlate_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic [`MX_ADDR_W-1:0]  vaddr,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic [2:0]             dm_sel,
    input  logic                   overflow,
    input  logic                   in_exc,
    input  logic [`MX_EXC_W-1:0]   in_exc_code,
    input  logic [`MX_ADDR_W-1:0]  pc,
    input  logic                   eret_flush,
    input  tlb_entry_t             tlb,
    decode_if.src                  dec
);

    access_kind_t kind_d;
    access_size_t size_d;
    logic         mapped_d;
    logic         misaligned_d;

    always_comb begin
        if (is_store) begin
            kind_d = kind_store; // store wins over load
        end else if (is_load) begin
            kind_d = kind_load;
        end else begin
            kind_d = kind_none;
        end
    end

    // kseg0/kseg1 are unmapped
    assign mapped_d = (vaddr[31:30] != 2'b10);

    always_comb begin
        misaligned_d = 1'b0;
        if (kind_d == kind_store) begin
            case (dm_sel)
                `MX_SEL_BYTE: size_d = size_byte;
                `MX_SEL_HALF: size_d = size_half;
                default:      size_d = size_word;
            endcase
            // only sh and sw are checked
            misaligned_d = (dm_sel == `MX_SEL_WORD && vaddr[1:0] != 2'b00) ||
                           (dm_sel == `MX_SEL_HALF && vaddr[0]);
        end else begin
            case (dm_sel)
                `MX_SEL_LW:             size_d = size_word;
                `MX_SEL_LH, `MX_SEL_LHU: size_d = size_half;
                default:                size_d = size_byte;
            endcase
            if (kind_d == kind_load) begin
                misaligned_d = (size_d == size_word && vaddr[1:0] != 2'b00) ||
                               (size_d == size_half && vaddr[0]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec.valid <= 1'b0;
            dec.kind  <= kind_none;
        end else begin
            dec.valid <= req_valid;
            dec.kind  <= req_valid ? kind_d : kind_none;
        end
    end

    always_ff @(posedge clk) begin
        dec.vaddr          <= vaddr;
        dec.size_word_load <= size_d;
        dec.mapped         <= mapped_d;
        dec.misaligned     <= misaligned_d;
        dec.overflow       <= overflow;
        dec.in_exc         <= in_exc;
        dec.in_exc_code    <= in_exc_code;
        dec.pc             <= pc;
        dec.eret_flush     <= eret_flush;
        dec.tlb            <= tlb;
    end

endmodule

`default_nettype wire

/* verilog/access_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xlate_consts.svh"

module access_result import mem_xlate_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    exec_if.sink                   ex,
    output logic                   out_valid,
    output logic [`MX_ADDR_W-1:0]  paddr,
    output logic                   uncached,
    output logic                   dcache_valid,
    output logic                   uncache_valid,
    output logic [3:0]             wstrb,
    output logic                   exc,
    output logic [`MX_EXC_W-1:0]   exc_code,
    output logic [`MX_ADDR_W-1:0]  badvaddr,
    output logic                   tlb_refill
);

    logic                  live;  // access that reaches the cache
    logic [3:0]            wstrb_d;
    logic [`MX_ADDR_W-1:0] badvaddr_d;

    assign live = ex.valid && (ex.kind != kind_none) && !ex.exc && !ex.eret_flush;

    always_comb begin
        wstrb_d = 4'b0000;
        if (live && ex.kind == kind_store) begin
            case (ex.size)
                size_byte: wstrb_d = 4'b0001 << ex.paddr[1:0];
                size_half: wstrb_d = ex.paddr[1] ? 4'b1100 : 4'b0011;
                default:   wstrb_d = 4'b1111;
            endcase
        end
    end

    always_comb begin
        case (ex.badvaddr_sel)
            bad_zero:  badvaddr_d = '0;
            bad_vaddr: badvaddr_d = ex.vaddr;
            default:   badvaddr_d = ex.pc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid     <= 1'b0;
            dcache_valid  <= 1'b0;
            uncache_valid <= 1'b0;
            wstrb         <= 4'b0000;
            exc           <= 1'b0;
            tlb_refill    <= 1'b0;
        end else begin
            out_valid     <= ex.valid;
            dcache_valid  <= live && !ex.uncached;
            uncache_valid <= live && ex.uncached;
            wstrb         <= wstrb_d;
            exc           <= ex.valid && ex.exc;
            tlb_refill    <= ex.valid && ex.tlb_refill;
        end
    end

    always_ff @(posedge clk) begin
        paddr    <= ex.paddr;
        uncached <= ex.uncached;
        exc_code <= ex.exc_code;
        badvaddr <= badvaddr_d;
    end

endmodule

`default_nettype wire

/* verilog/mem_xlate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xlate_consts.svh"

module mem_xlate import mem_xlate_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  logic [`MX_ADDR_W-1:0]  vaddr,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic [2:0]             dm_sel,
    input  logic                   overflow,
    input  logic                   in_exc,
    input  logic [`MX_EXC_W-1:0]   in_exc_code,
    input  logic [`MX_ADDR_W-1:0]  pc,
    input  logic                   eret_flush,
    input  logic                   tlb_found,
    input  logic                   tlb_v,
    input  logic                   tlb_d,
    input  logic [`MX_PFN_W-1:0]   tlb_pfn,
    output logic                   out_valid,
    output logic [`MX_ADDR_W-1:0]  paddr,
    output logic                   uncached,
    output logic                   dcache_valid,
    output logic                   uncache_valid,
    output logic [3:0]             wstrb,
    output logic                   exc,
    output logic [`MX_EXC_W-1:0]   exc_code,
    output logic [`MX_ADDR_W-1:0]  badvaddr,
    output logic                   tlb_refill
);

    tlb_entry_t tlb;

    decode_if dec_bus ();
    exec_if   ex_bus ();

    // lookup result belongs to the request of the same cycle
    assign tlb = '{found: tlb_found, valid: tlb_v, dirty: tlb_d, pfn: tlb_pfn};

    access_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .vaddr       (vaddr),
        .is_load     (is_load),
        .is_store    (is_store),
        .dm_sel      (dm_sel),
        .overflow    (overflow),
        .in_exc      (in_exc),
        .in_exc_code (in_exc_code),
        .pc          (pc),
        .eret_flush  (eret_flush),
        .tlb         (tlb),
        .dec         (dec_bus)
    );

    tlb_check u_check (
        .dec (dec_bus),
        .ex  (ex_bus)
    );

    access_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex            (ex_bus),
        .out_valid     (out_valid),
        .paddr         (paddr),
        .uncached      (uncached),
        .dcache_valid  (dcache_valid),
        .uncache_valid (uncache_valid),
        .wstrb         (wstrb),
        .exc           (exc),
        .exc_code      (exc_code),
        .badvaddr      (badvaddr),
        .tlb_refill    (tlb_refill)
    );

endmodule

`default_nettype wire

/* verilog/mem_xlate_consts.svh */
`ifndef MEM_XLATE_CONSTS_SVH
`define MEM_XLATE_CONSTS_SVH

// field widths
`define MX_ADDR_W   32
`define MX_PFN_W    20
`define MX_OFFSET_W 12
`define MX_EXC_W    5

// exception codes in cp0 cause encoding
`define MX_EXC_MOD  5'd1
`define MX_EXC_TLBL 5'd2
`define MX_EXC_TLBS 5'd3
`define MX_EXC_ADEL 5'd4
`define MX_EXC_ADES 5'd5
`define MX_EXC_OV   5'd12

`define MX_SEL_BYTE 3'b000 // sb
`define MX_SEL_HALF 3'b001 // sh
`define MX_SEL_WORD 3'b010 // sw
`define MX_SEL_LW   3'b111
`define MX_SEL_LH   3'b101
`define MX_SEL_LHU  3'b110

// physical bits 31:16 of the uncached window
`define MX_UNCACHED_BASE 16'h1faf

`endif

/* verilog/mem_xlate_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xlate_consts.svh"

interface decode_if import mem_xlate_pkg::*;;
    logic                   valid;
    logic [`MX_ADDR_W-1:0]  vaddr;
    access_kind_t           kind;
    access_size_t           size_word_load; // access size from dm_sel
    logic                   mapped;
    logic                   misaligned;
    logic                   overflow;
    logic                   in_exc;
    logic [`MX_EXC_W-1:0]   in_exc_code;
    logic [`MX_ADDR_W-1:0]  pc;
    logic                   eret_flush;
    tlb_entry_t             tlb;

    modport src (output valid, vaddr, kind, size_word_load, mapped, misaligned,
                 overflow, in_exc, in_exc_code, pc, eret_flush, tlb);
    modport sink (input valid, vaddr, kind, size_word_load, mapped, misaligned,
                  overflow, in_exc, in_exc_code, pc, eret_flush, tlb);
endinterface

interface exec_if import mem_xlate_pkg::*;;
    logic                   valid;
    access_kind_t           kind;
    access_size_t           size;
    logic                   eret_flush;
    logic [`MX_ADDR_W-1:0]  paddr;
    logic                   uncached;
    logic                   exc;
    logic [`MX_EXC_W-1:0]   exc_code;
    badvaddr_sel_t          badvaddr_sel;
    logic                   tlb_refill;
    logic [`MX_ADDR_W-1:0]  vaddr;
    logic [`MX_ADDR_W-1:0]  pc;

    modport src (output valid, kind, size, eret_flush, paddr, uncached, exc, exc_code,
                 badvaddr_sel, tlb_refill, vaddr, pc);
    modport sink (input valid, kind, size, eret_flush, paddr, uncached, exc, exc_code,
                  badvaddr_sel, tlb_refill, vaddr, pc);
endinterface

`default_nettype wire

/* verilog/mem_xlate_pkg.sv */
`default_nettype none

`include "mem_xlate_consts.svh"

package mem_xlate_pkg;

    typedef enum logic [1:0] {
        kind_none  = 2'd0,
        kind_load  = 2'd1,
        kind_store = 2'd2
    } access_kind_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    // source of the bad virtual address
    typedef enum logic [1:0] {
        bad_zero  = 2'd0, // overflow
        bad_vaddr = 2'd1,
        bad_pc    = 2'd2  // earlier exception passed through
    } badvaddr_sel_t;

    // data-side tlb lookup result of 23 bits
    typedef struct packed {
        logic                  found;
        logic                  valid;
        logic                  dirty;
        logic [`MX_PFN_W-1:0]  pfn;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* verilog/tlb_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_xlate_consts.svh"

module tlb_check import mem_xlate_pkg::*; (
    decode_if.sink dec,
    exec_if.src    ex
);

    logic                  is_store;
    logic                  is_load;
    logic                  tlb_access;
    logic                  tlb_bad;  // miss or invalid entry
    logic [`MX_ADDR_W-1:0] paddr;

    assign is_store   = (dec.kind == kind_store);
    assign is_load    = (dec.kind == kind_load);
    assign tlb_access = dec.mapped && !dec.in_exc && (dec.kind != kind_none);
    assign tlb_bad    = !dec.tlb.found || !dec.tlb.valid;

    // unmapped segments drop the top three bits
    assign paddr = dec.mapped ? {dec.tlb.pfn, dec.vaddr[`MX_OFFSET_W-1:0]}
                              : {3'b000, dec.vaddr[`MX_ADDR_W-4:0]};

    assign ex.paddr    = paddr;
    assign ex.uncached = (paddr[31:16] == `MX_UNCACHED_BASE);

    assign ex.valid      = dec.valid;
    assign ex.kind       = dec.kind;
    assign ex.size       = dec.size_word_load;
    assign ex.eret_flush = dec.eret_flush;
    assign ex.vaddr      = dec.vaddr;
    assign ex.pc         = dec.pc;

    // earlier exception outranks everything raised here
    always_comb begin
        ex.exc          = 1'b1;
        ex.exc_code     = dec.in_exc_code;
        ex.badvaddr_sel = bad_vaddr;
        ex.tlb_refill   = 1'b0;
        if (dec.overflow && !dec.in_exc) begin
            ex.exc_code     = `MX_EXC_OV;
            ex.badvaddr_sel = bad_zero;
        end else if (is_store && dec.misaligned && !dec.in_exc) begin
            ex.exc_code = `MX_EXC_ADES;
        end else if (is_load && dec.misaligned && !dec.in_exc) begin
            ex.exc_code = `MX_EXC_ADEL;
        end else if (tlb_access && is_store && tlb_bad) begin
            ex.exc_code   = `MX_EXC_TLBS;
            ex.tlb_refill = !dec.tlb.found;
        end else if (tlb_access && is_store && !dec.tlb.dirty) begin
            ex.exc_code = `MX_EXC_MOD; // hit on a clean page
        end else if (tlb_access && is_load && tlb_bad) begin
            ex.exc_code   = `MX_EXC_TLBL;
            ex.tlb_refill = !dec.tlb.found;
        end else begin
            ex.exc          = dec.in_exc;
            ex.badvaddr_sel = bad_pc;
        end
    end

endmodule

`default_nettype wire
